// File: l2_cache.f
verilog/l2_pkg.sv
verilog/l2_update_if.sv
verilog/l2_array.sv
verilog/l2_tag_stage.sv
verilog/l2_lru_stage.sv
verilog/l2_data_stage.sv
verilog/l2_control.sv
verilog/l2_cache.sv
testbench/l2_mem_model.sv
testbench/l2_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module l2_cache_tb -f l2_cache.f -o l2_cache_sim &&
	./obj_dir/l2_cache_sim > sim.log 2>&1 || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

// File: testbench/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

	localparam int CYCLE_LIMIT = 6000;  // about 80 requests of under 40 cycles each

	logic clk;
	logic arst_n;
	logic mem_read;
	logic mem_write;
	logic [15:0] mem_address;
	logic [127:0] mem_wdata;
	logic [127:0] mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	logic [15:0] pmem_address;
	logic [127:0] pmem_wdata;
	logic [127:0] pmem_rdata;
	logic pmem_resp;

	// ========================================
	// reference model of the cache and memory
	// ========================================
	logic [l2_pkg::TAG_W-1:0] m_tag [l2_pkg::SETS][l2_pkg::WAYS];
	logic m_valid [l2_pkg::SETS][l2_pkg::WAYS];
	logic m_dirty [l2_pkg::SETS][l2_pkg::WAYS];
	l2_pkg::age_t m_age [l2_pkg::SETS][l2_pkg::WAYS];
	logic [l2_pkg::LINE_W-1:0] m_data [l2_pkg::SETS][l2_pkg::WAYS];
	logic [l2_pkg::LINE_W-1:0] ref_mem [1 << l2_pkg::LINE_NUM_W];

	int checks;
	int line_errs;
	int addr_errs;
	int flag_errs;
	int other_errs;
	int cycle_count;

	l2_cache dut_i (.*);
	l2_mem_model mem_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, cache state %s", cycle_count, dut_i.state.name());
		$display("Verification failed");
		$finish;
	end

	function automatic logic [127:0] memory_line(input logic [11:0] line);
		return {8{line, 4'h0}} ^ {32'h0123_4567, 32'h89ab_cdef, 32'h3c3c_a5a5, 32'h7e81_1f2e};
	endfunction

	function automatic l2_pkg::l2_addr_u make_addr(input logic [6:0] tag, input logic [4:0] index);
		return {tag, index, 4'($urandom)};  // the offset must not matter
	endfunction

	function automatic logic [127:0] rand_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// an empty way is taken first, otherwise the oldest one
	function automatic l2_pkg::way_t model_victim(input int s);
		for (int w = 0; w < l2_pkg::WAYS; w++) begin
			if (!m_valid[s][w]) return l2_pkg::way_t'(w);
		end
		for (int w = 0; w < l2_pkg::WAYS; w++) begin
			if (m_age[s][w] == 2'd3) return l2_pkg::way_t'(w);
		end
		return '0;
	endfunction

	function automatic void model_touch(input int s, input l2_pkg::way_t way);
		l2_pkg::age_t old;
		old = m_age[s][way];
		for (int w = 0; w < l2_pkg::WAYS; w++) begin
			if (w == int'(way)) begin
				m_age[s][w] = '0;
			end else if (m_age[s][w] < old) begin
				m_age[s][w] = m_age[s][w] + 1'b1;
			end
		end
	endfunction

	// ========================================
	// compare tasks
	// ========================================
	task automatic check_line(input string name, input logic [l2_pkg::LINE_W-1:0] got,
			input logic [l2_pkg::LINE_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			line_errs++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input l2_pkg::l2_addr_u got,
			input l2_pkg::l2_addr_u exp);
		checks++;
		if (got !== exp) begin
			addr_errs++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			flag_errs++;
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		for (int s = 0; s < l2_pkg::SETS; s++) begin
			for (int w = 0; w < l2_pkg::WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_age[s][w] = l2_pkg::age_t'(w);
			end
		end
	endtask

	// one request, starting and ending 1 ns after a rising edge
	task automatic access(input logic wr, input l2_pkg::l2_addr_u a, input logic [127:0] wdata);
		int s;
		int way;
		int lat;
		int reads;
		int writes;
		logic miss;
		logic wb;
		logic saw_read;
		logic saw_write;
		l2_pkg::l2_addr_u wb_addr;
		logic [127:0] wb_line;
		logic [127:0] exp_rdata;
		s = int'(a.f.index);
		way = -1;
		for (int w = 0; w < l2_pkg::WAYS; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == a.f.tag) begin
				way = w;
			end
		end
		miss = (way < 0);
		wb = 1'b0;
		if (miss) begin
			way = int'(model_victim(s));
			wb = m_valid[s][way] && m_dirty[s][way];
			wb_addr = {m_tag[s][way], a.f.index, 4'h0};
			wb_line = m_data[s][way];
			if (wb) begin
				ref_mem[wb_addr.l.line] = wb_line;
			end
			m_tag[s][way] = a.f.tag;
			m_valid[s][way] = 1'b1;
			m_dirty[s][way] = 1'b0;
			m_data[s][way] = ref_mem[a.l.line];
		end
		exp_rdata = m_data[s][way];
		model_touch(s, l2_pkg::way_t'(way));
		if (wr) begin
			m_data[s][way] = wdata;
			m_dirty[s][way] = 1'b1;
		end
		reads = mem_i.read_count;
		writes = mem_i.write_count;
		mem_read = !wr;
		mem_write = wr;
		mem_address = a;
		mem_wdata = wdata;
		lat = 0;
		@(negedge clk);
		saw_read = pmem_read;
		saw_write = pmem_write;
		while (!mem_resp) begin
			lat++;
			@(negedge clk);
			saw_read = saw_read || pmem_read;
			saw_write = saw_write || pmem_write;
		end
		if (!wr) begin
			check_line("mem_rdata", mem_rdata, exp_rdata);
		end
		reads = mem_i.read_count - reads;
		writes = mem_i.write_count - writes;
		check_flag("pmem_read", saw_read, miss);
		check_flag("pmem_write", saw_write, wb);
		if (miss) begin
			check_addr("pmem_address of fill", mem_i.last_read_addr, {a.l.line, 4'h0});
		end
		if (wb) begin
			check_addr("pmem_address of writeback", mem_i.last_write_addr, wb_addr);
			check_line("pmem_wdata", mem_i.last_write_data, wb_line);
		end
		if (reads > 1 || writes > 1) begin
			other_errs++;
			$display("at %0t: request to %h caused %0d reads and %0d writes", $time, a, reads, writes);
		end
		if (!miss && lat != 1) begin
			other_errs++;
			$display("at %0t: hit on %h answered after %0d cycles instead of 1", $time, a, lat);
		end
		@(posedge clk);
		#1;
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	// ========================================
	// directed tests
	// ========================================
	task automatic test_cold_miss();
		for (int i = 0; i < 4; i++) begin
			access(1'b0, make_addr(7'($urandom), 5'(i * 7)), '0);
		end
	endtask

	task automatic test_hit_repeat();
		logic [6:0] tag;
		tag = 7'($urandom);
		repeat (3) access(1'b0, make_addr(tag, 5'd9), '0);
	endtask

	task automatic test_write_read();
		logic [6:0] tag;
		tag = 7'($urandom);
		access(1'b0, make_addr(tag, 5'd11), '0);
		access(1'b1, make_addr(tag, 5'd11), rand_line());
		access(1'b0, make_addr(tag, 5'd11), '0);
		access(1'b1, make_addr(tag + 7'd1, 5'd11), rand_line());  // allocates first
		access(1'b0, make_addr(tag + 7'd1, 5'd11), '0);
	endtask

	// order lists the fill sequence two bits per step and again marks the tags that hit afterwards
	task automatic test_lru_evict(input logic [4:0] index, input logic [7:0] order,
			input logic [3:0] again);
		logic [6:0] base;
		logic [6:0] tags [5];
		logic [6:0] gone;
		base = 7'($urandom);
		for (int k = 0; k < 5; k++) begin
			tags[k] = base + 7'(k * 17);
		end
		for (int k = 0; k < 4; k++) begin
			access(1'b0, make_addr(tags[order[2*k +: 2]], index), '0);
		end
		for (int k = 0; k < 4; k++) begin
			if (again[k]) begin
				access(1'b0, make_addr(tags[k], index), '0);
			end
		end
		gone = m_tag[index][model_victim(int'(index))];
		access(1'b0, make_addr(tags[4], index), '0);
		access(1'b0, make_addr(gone, index), '0);  // the evicted line comes back from memory
	endtask

	task automatic test_dirty_evict();
		logic [6:0] tag;
		tag = 7'($urandom);
		for (int k = 0; k < 4; k++) begin
			access(1'b1, make_addr(tag + 7'(k * 5), 5'd20), rand_line());
		end
		access(1'b0, make_addr(tag + 7'd20, 5'd20), '0);
		access(1'b0, make_addr(tag, 5'd20), '0);
		for (int k = 0; k < 5; k++) begin
			access(1'b0, make_addr(tag + 7'(k * 5), 5'd21), '0);  // these lines stay clean
		end
	endtask

	task automatic test_random_mix();
		for (int i = 0; i < 20; i++) begin
			access(1'($urandom), make_addr(7'(40 + $urandom_range(5, 0)),
				5'(30 + $urandom_range(1, 0))), rand_line());
		end
	endtask

	task automatic test_mid_reset();
		l2_pkg::l2_addr_u a;
		a = make_addr(7'($urandom), 5'd12);
		access(1'b0, a, '0);
		access(1'b0, a, '0);
		apply_reset();
		access(1'b0, a, '0);
	endtask

	initial begin
		void'($urandom(44));
		checks = 0;
		line_errs = 0;
		addr_errs = 0;
		flag_errs = 0;
		other_errs = 0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		for (int i = 0; i < (1 << l2_pkg::LINE_NUM_W); i++) begin
			ref_mem[i] = memory_line(12'(i));
		end
		apply_reset();
		test_cold_miss();
		test_hit_repeat();
		test_write_read();
		test_lru_evict(5'd3, {2'd3, 2'd2, 2'd1, 2'd0}, 4'b0101);
		test_lru_evict(5'd4, {2'd0, 2'd2, 2'd3, 2'd1}, 4'b1010);
		test_dirty_evict();
		test_random_mix();
		test_mid_reset();
		$display("summary: %0d checks, errors line %0d, address %0d, flag %0d, protocol %0d",
			checks, line_errs, addr_errs, flag_errs, other_errs);
		if (line_errs + addr_errs + flag_errs + other_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: testbench/l2_mem_model.sv
`timescale 1ns/1ps

module l2_mem_model (
	input  logic clk,
	input  logic arst_n,
	input  logic pmem_read,
	input  logic pmem_write,
	input  logic [15:0] pmem_address,
	input  logic [127:0] pmem_wdata,
	output logic [127:0] pmem_rdata,
	output logic pmem_resp
);

	logic [127:0] stored [logic [11:0]];  // lines written back so far
	logic busy;
	int remaining;

	// ========================================
	// write log, read by the testbench
	// ========================================
	int read_count;
	int write_count;
	logic [15:0] last_read_addr;
	logic [15:0] last_write_addr;
	logic [127:0] last_write_data;

	// lines never written hold a value built from the whole line address
	function automatic logic [127:0] fill_line(input logic [11:0] line);
		return {8{line, 4'h0}} ^ {32'h0123_4567, 32'h89ab_cdef, 32'h3c3c_a5a5, 32'h7e81_1f2e};
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			remaining <= 0;
			pmem_resp <= 1'b0;
			pmem_rdata <= '0;
			read_count <= 0;
			write_count <= 0;
		end else begin
			pmem_resp <= 1'b0;
			if (pmem_resp) begin
				busy <= 1'b0;  // the cache drops its request on this edge
			end else if ((pmem_read || pmem_write) && !busy) begin
				busy <= 1'b1;
				remaining <= $urandom_range(6, 1);
			end else if (busy && remaining > 1) begin
				remaining <= remaining - 1;
			end else if (busy && pmem_write) begin
				pmem_resp <= 1'b1;
				stored[pmem_address[15:4]] = pmem_wdata;
				write_count <= write_count + 1;
				last_write_addr <= pmem_address;
				last_write_data <= pmem_wdata;
			end else if (busy) begin
				pmem_resp <= 1'b1;
				pmem_rdata <= stored.exists(pmem_address[15:4]) ? stored[pmem_address[15:4]]
					: fill_line(pmem_address[15:4]);
				read_count <= read_count + 1;
				last_read_addr <= pmem_address;
			end
		end
	end

endmodule

// File: verilog/l2_array.sv
`timescale 1ns/1ps

module l2_array #(
	parameter int WIDTH = 1
) (
	input  logic clk,
	input  logic arst_n,
	input  logic we,
	input  logic [l2_pkg::SETS_LOG2-1:0] index,
	input  logic [WIDTH-1:0] wdata,
	output logic [WIDTH-1:0] rdata
);

	logic [WIDTH-1:0] mem [l2_pkg::SETS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < l2_pkg::SETS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[index] <= wdata;
		end
	end

	assign rdata = mem[index];  // read is visible in the same cycle

endmodule

// File: verilog/l2_cache.sv
`timescale 1ns/1ps

module l2_cache (
	input  logic clk,
	input  logic arst_n,
	input  logic mem_read,
	input  logic mem_write,
	input  logic [15:0] mem_address,
	input  logic [127:0] mem_wdata,
	output logic [127:0] mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic [15:0] pmem_address,
	output logic [127:0] pmem_wdata,
	input  logic [127:0] pmem_rdata,
	input  logic pmem_resp
);

	l2_pkg::l2_addr_u addr;
	logic hit;
	l2_pkg::way_t hit_way;
	l2_pkg::way_t victim_way;
	logic [l2_pkg::WAYS-1:0] valid_vec;
	logic [l2_pkg::WAYS-1:0] dirty_vec;
	logic [l2_pkg::WAYS-1:0][l2_pkg::TAG_W-1:0] victim_tags;
	l2_pkg::l2_state_e state;

	assign addr = mem_address;

	l2_update_if upd ();

	// ========================================
	// lookup, replacement and data stages
	// ========================================
	l2_tag_stage tag_i (
		.clk,
		.arst_n,
		.addr,
		.upd,
		.hit,
		.hit_way,
		.valid_vec,
		.dirty_vec,
		.victim_tags
	);

	l2_lru_stage lru_i (
		.clk,
		.arst_n,
		.index(addr.f.index),
		.upd,
		.valid_vec,
		.victim_way
	);

	l2_data_stage data_i (
		.clk,
		.arst_n,
		.index(addr.f.index),
		.upd,
		.hit_way,
		.victim_way,
		.mem_wdata,
		.pmem_rdata,
		.rdata(mem_rdata),
		.wb_data(pmem_wdata)
	);

	l2_control ctrl_i (
		.clk,
		.arst_n,
		.mem_read,
		.mem_write,
		.addr,
		.hit,
		.hit_way,
		.victim_way,
		.valid_vec,
		.dirty_vec,
		.victim_tags,
		.upd,
		.mem_resp,
		.pmem_read,
		.pmem_write,
		.pmem_resp,
		.pmem_address,
		.state
	);

endmodule

// File: verilog/l2_control.sv
`timescale 1ns/1ps

module l2_control (
	input  logic clk,
	input  logic arst_n,
	input  logic mem_read,
	input  logic mem_write,
	input  l2_pkg::l2_addr_u addr,
	input  logic hit,
	input  l2_pkg::way_t hit_way,
	input  l2_pkg::way_t victim_way,
	input  logic [l2_pkg::WAYS-1:0] valid_vec,
	input  logic [l2_pkg::WAYS-1:0] dirty_vec,
	input  logic [l2_pkg::WAYS-1:0][l2_pkg::TAG_W-1:0] victim_tags,
	l2_update_if.ctrl upd,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	input  logic pmem_resp,
	output logic [15:0] pmem_address,
	output l2_pkg::l2_state_e state
);

	l2_pkg::l2_state_e next_state;
	l2_pkg::l2_addr_u line_addr;
	logic [l2_pkg::WAYS-1:0] hit_onehot;
	logic [l2_pkg::WAYS-1:0] victim_onehot;

	always_comb begin
		hit_onehot = '0;
		hit_onehot[hit_way] = 1'b1;
		victim_onehot = '0;
		victim_onehot[victim_way] = 1'b1;
	end

	// ========================================
	// physical address
	// ========================================
	// a writeback goes to the victim's own line, a fill to the requested one
	always_comb begin
		line_addr = addr;
		if (state == l2_pkg::st_writeback) begin
			line_addr.l.line = {victim_tags[victim_way], addr.f.index};
		end
		line_addr.l.offset = '0;
	end

	assign pmem_address = line_addr;

	// ========================================
	// state machine
	// ========================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= l2_pkg::st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		upd.tag_we = '0;
		upd.valid_we = '0;
		upd.dirty_we = '0;
		upd.dirty_val = 1'b0;
		upd.data_we = '0;
		upd.fill_sel = 1'b0;
		upd.lru_touch = 1'b0;
		upd.touch_way = hit_way;
		case (state)
			l2_pkg::st_idle: begin
				if (mem_read || mem_write) begin
					next_state = l2_pkg::st_check;
				end
			end
			l2_pkg::st_check: begin
				if (hit) begin
					mem_resp = 1'b1;
					upd.lru_touch = 1'b1;
					if (mem_write) begin  // store hit marks the line dirty
						upd.data_we = hit_onehot;
						upd.dirty_we = hit_onehot;
						upd.dirty_val = 1'b1;
					end
					next_state = l2_pkg::st_idle;
				end else if (valid_vec[victim_way] && dirty_vec[victim_way]) begin
					next_state = l2_pkg::st_writeback;
				end else begin
					next_state = l2_pkg::st_fill;
				end
			end
			l2_pkg::st_writeback: begin
				pmem_write = 1'b1;
				if (pmem_resp) begin
					next_state = l2_pkg::st_fill;
				end
			end
			l2_pkg::st_fill: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					upd.tag_we = victim_onehot;
					upd.valid_we = victim_onehot;
					upd.dirty_we = victim_onehot;
					upd.data_we = victim_onehot;
					upd.fill_sel = 1'b1;
					next_state = l2_pkg::st_check;  // the retry then hits
				end
			end
			default: next_state = l2_pkg::st_idle;
		endcase
	end

endmodule

// File: verilog/l2_data_stage.sv
`timescale 1ns/1ps

module l2_data_stage (
	input  logic clk,
	input  logic arst_n,
	input  logic [l2_pkg::SETS_LOG2-1:0] index,
	l2_update_if.data upd,
	input  l2_pkg::way_t hit_way,
	input  l2_pkg::way_t victim_way,
	input  logic [l2_pkg::LINE_W-1:0] mem_wdata,
	input  logic [l2_pkg::LINE_W-1:0] pmem_rdata,
	output logic [l2_pkg::LINE_W-1:0] rdata,
	output logic [l2_pkg::LINE_W-1:0] wb_data
);

	logic [l2_pkg::LINE_W-1:0] wdata;
	logic [l2_pkg::LINE_W-1:0] way_line [l2_pkg::WAYS];

	// fills take the memory line, store hits take the requester line
	assign wdata = upd.fill_sel ? pmem_rdata : mem_wdata;

	for (genvar w = 0; w < l2_pkg::WAYS; w++) begin : g_way
		l2_array #(
			.WIDTH(l2_pkg::LINE_W)
		) data_col (
			.clk,
			.arst_n,
			.we(upd.data_we[w]),
			.index,
			.wdata,
			.rdata(way_line[w])
		);
	end

	assign rdata = way_line[hit_way];
	assign wb_data = way_line[victim_way];  // stays stable for the whole writeback

endmodule

// File: verilog/l2_lru_stage.sv
`timescale 1ns/1ps

module l2_lru_stage (
	input  logic clk,
	input  logic arst_n,
	input  logic [l2_pkg::SETS_LOG2-1:0] index,
	l2_update_if.lru upd,
	input  logic [l2_pkg::WAYS-1:0] valid_vec,
	output l2_pkg::way_t victim_way
);

	l2_pkg::age_t ages [l2_pkg::SETS][l2_pkg::WAYS];
	l2_pkg::age_t touched_age;

	assign touched_age = ages[index][upd.touch_way];

	// ages within a set always stay a permutation of 0..3
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < l2_pkg::SETS; s++) begin
				for (int w = 0; w < l2_pkg::WAYS; w++) begin
					ages[s][w] <= l2_pkg::age_t'(w);
				end
			end
		end else if (upd.lru_touch) begin
			for (int w = 0; w < l2_pkg::WAYS; w++) begin
				if (l2_pkg::way_t'(w) == upd.touch_way) begin
					ages[index][w] <= '0;
				end else if (ages[index][w] < touched_age) begin
					ages[index][w] <= ages[index][w] + 1'b1;  // younger ways move back one
				end
			end
		end
	end

	// an empty way is preferred over evicting anything
	always_comb begin
		victim_way = '0;
		for (int w = l2_pkg::WAYS - 1; w >= 0; w--) begin
			if (ages[index][w] == l2_pkg::age_t'(l2_pkg::WAYS - 1)) begin
				victim_way = l2_pkg::way_t'(w);
			end
		end
		for (int w = l2_pkg::WAYS - 1; w >= 0; w--) begin
			if (!valid_vec[w]) begin
				victim_way = l2_pkg::way_t'(w);
			end
		end
	end

endmodule

// File: verilog/l2_pkg.sv
package l2_pkg;

	// ========================================
	// cache geometry
	// ========================================
	localparam int WAYS = 4;
	localparam int SETS_LOG2 = 5;
	localparam int SETS = 1 << SETS_LOG2;
	localparam int TAG_W = 7;
	localparam int OFFSET_W = 4;
	localparam int LINE_NUM_W = TAG_W + SETS_LOG2;
	localparam int LINE_W = 128;

	typedef logic [1:0] way_t;
	typedef logic [1:0] age_t;  // 0 is the most recently used way

	// ========================================
	// address decoding
	// ========================================
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [SETS_LOG2-1:0] index;
		logic [OFFSET_W-1:0] offset;
	} addr_fields_t;

	// the line number is tag and index together, as memory sees it
	typedef struct packed {
		logic [LINE_NUM_W-1:0] line;
		logic [OFFSET_W-1:0] offset;
	} addr_line_t;

	typedef union packed {
		addr_fields_t f;
		addr_line_t l;
	} l2_addr_u;

	typedef enum logic [1:0] {
		st_idle,
		st_check,
		st_writeback,
		st_fill
	} l2_state_e;

endpackage

// File: verilog/l2_tag_stage.sv
`timescale 1ns/1ps

module l2_tag_stage (
	input  logic clk,
	input  logic arst_n,
	input  l2_pkg::l2_addr_u addr,
	l2_update_if.tag upd,
	output logic hit,
	output l2_pkg::way_t hit_way,
	output logic [l2_pkg::WAYS-1:0] valid_vec,
	output logic [l2_pkg::WAYS-1:0] dirty_vec,
	output logic [l2_pkg::WAYS-1:0][l2_pkg::TAG_W-1:0] victim_tags
);

	logic [l2_pkg::WAYS-1:0] hit_vec;

	// ========================================
	// per-way tag, valid and dirty columns
	// ========================================
	for (genvar w = 0; w < l2_pkg::WAYS; w++) begin : g_way
		l2_array #(
			.WIDTH(l2_pkg::TAG_W)
		) tag_col (
			.clk,
			.arst_n,
			.we(upd.tag_we[w]),
			.index(addr.f.index),
			.wdata(addr.f.tag),
			.rdata(victim_tags[w])
		);

		// a valid column is only ever written with 1, reset is what clears it
		l2_array #(
			.WIDTH(1)
		) valid_col (
			.clk,
			.arst_n,
			.we(upd.valid_we[w]),
			.index(addr.f.index),
			.wdata(1'b1),
			.rdata(valid_vec[w])
		);

		l2_array #(
			.WIDTH(1)
		) dirty_col (
			.clk,
			.arst_n,
			.we(upd.dirty_we[w]),
			.index(addr.f.index),
			.wdata(upd.dirty_val),
			.rdata(dirty_vec[w])
		);

		assign hit_vec[w] = valid_vec[w] && (victim_tags[w] == addr.f.tag);
	end

	// at most one way can match, so the priority order does not matter
	always_comb begin
		hit_way = '0;
		for (int w = l2_pkg::WAYS - 1; w >= 0; w--) begin
			if (hit_vec[w]) begin
				hit_way = l2_pkg::way_t'(w);
			end
		end
	end

	assign hit = |hit_vec;

endmodule

// File: verilog/l2_update_if.sv
`timescale 1ns/1ps

interface l2_update_if;

	// per-way write enables, one hot
	logic [l2_pkg::WAYS-1:0] tag_we;
	logic [l2_pkg::WAYS-1:0] valid_we;
	logic [l2_pkg::WAYS-1:0] dirty_we;
	logic [l2_pkg::WAYS-1:0] data_we;
	logic dirty_val;
	logic fill_sel;  // set when the line comes from physical memory
	logic lru_touch;
	l2_pkg::way_t touch_way;

	modport ctrl (
		output tag_we, valid_we, dirty_we, data_we,
		output dirty_val, fill_sel, lru_touch, touch_way
	);

	modport tag (
		input tag_we, valid_we, dirty_we, dirty_val
	);

	modport lru (
		input lru_touch, touch_way
	);

	modport data (
		input data_we, fill_sel
	);

endinterface
